// ==== hw/mips_pkg.sv ====
package mips_pkg;

	//*******************************************************************
	// Widths
	//*******************************************************************
	localparam int data_w     = 32;
	localparam int iaddr_w    = 6;
	localparam int daddr_w    = 6;
	localparam int reg_addr_w = 5;

	//*******************************************************************
	// Opcodes, instruction bits 31:26
	//*******************************************************************
	localparam logic [5:0] op_rtype = 6'b000000;
	localparam logic [5:0] op_addi  = 6'b000101;
	localparam logic [5:0] op_andi  = 6'b000111;
	localparam logic [5:0] op_ori   = 6'b000110;
	localparam logic [5:0] op_lui   = 6'b001010;
	localparam logic [5:0] op_lw    = 6'b100011;
	localparam logic [5:0] op_sw    = 6'b101011;
	localparam logic [5:0] op_beq   = 6'b000100;
	localparam logic [5:0] op_bne   = 6'b010001;
	localparam logic [5:0] op_j     = 6'b000010;

	// R-type function codes, bits 5:0
	localparam logic [5:0] fn_add = 6'b100000;
	localparam logic [5:0] fn_sub = 6'b100010;
	localparam logic [5:0] fn_and = 6'b100100;
	localparam logic [5:0] fn_or  = 6'b111000;
	localparam logic [5:0] fn_xor = 6'b101111;
	localparam logic [5:0] fn_nor = 6'b100111;

	//*******************************************************************
	// Enumerated controls
	//*******************************************************************
	typedef enum logic [3:0]
	{
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_lui
	} alu_op_t;

	// Source of an execute operand
	typedef enum logic [1:0]
	{
		fwd_reg,
		fwd_mem,
		fwd_wb
	} fwd_sel_t;

endpackage

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps
module fetch_stage
(
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         stall,
	input  logic                         redirect,
	input  logic [mips_pkg::iaddr_w-1:0] target_pc,
	input  logic [mips_pkg::data_w-1:0]  idata,
	output logic [mips_pkg::iaddr_w-1:0] iaddr,
	output logic [mips_pkg::data_w-1:0]  d_ir,
	output logic [mips_pkg::iaddr_w-1:0] d_pc,
	output logic                         d_valid
);

	logic [mips_pkg::iaddr_w-1:0] pc;

	assign iaddr = pc;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc      <= '0;
			d_valid <= 1'b0;
		end
		else if (redirect)
		begin
			pc      <= target_pc;
			d_valid <= 1'b0; // Drop the wrong-path fetch
		end
		else if (!stall)
		begin
			pc      <= pc + {{(mips_pkg::iaddr_w-1){1'b0}}, 1'b1};
			d_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stall)
		begin
			d_ir <= idata;
			d_pc <= pc;
		end
	end

endmodule

// ==== hw/decode_unit.sv ====
`timescale 1ns/1ps
module decode_unit
(
	input  logic [mips_pkg::data_w-1:0]     d_ir,
	input  logic                            d_valid,
	output logic [mips_pkg::reg_addr_w-1:0] rs,
	output logic [mips_pkg::reg_addr_w-1:0] rt,
	output logic [mips_pkg::reg_addr_w-1:0] rd,
	output logic [15:0]                     imm,
	output mips_pkg::alu_op_t               alu_op,
	output logic                            use_imm,
	output logic                            zero_ext,
	output logic                            is_load,
	output logic                            is_store,
	output logic                            reg_write,
	output logic                            is_beq,
	output logic                            is_bne,
	output logic                            is_jump
);

	logic [5:0] op;
	logic [5:0] fn;

	assign op  = d_ir[31:26];
	assign fn  = d_ir[5:0];
	assign rs  = d_ir[25:21];
	assign rt  = d_ir[20:16];
	assign imm = d_ir[15:0];

	// R-type writes rd, everything else rt
	assign rd = (op == mips_pkg::op_rtype) ? d_ir[15:11] : d_ir[20:16];

	always_comb
	begin
		alu_op    = mips_pkg::alu_add;
		use_imm   = 1'b0;
		zero_ext  = 1'b0;
		is_load   = 1'b0;
		is_store  = 1'b0;
		reg_write = 1'b0;
		is_beq    = 1'b0;
		is_bne    = 1'b0;
		is_jump   = 1'b0;
		if (d_valid)
		begin
			case (op)
				mips_pkg::op_rtype:
				begin
					reg_write = 1'b1;
					case (fn)
						mips_pkg::fn_add: alu_op = mips_pkg::alu_add;
						mips_pkg::fn_sub: alu_op = mips_pkg::alu_sub;
						mips_pkg::fn_and: alu_op = mips_pkg::alu_and;
						mips_pkg::fn_or:  alu_op = mips_pkg::alu_or;
						mips_pkg::fn_xor: alu_op = mips_pkg::alu_xor;
						mips_pkg::fn_nor: alu_op = mips_pkg::alu_nor;
						default:          reg_write = 1'b0; // Unknown function
					endcase
				end
				mips_pkg::op_addi: {use_imm, reg_write} = 2'b11;
				mips_pkg::op_andi:
				begin
					alu_op = mips_pkg::alu_and;
					{use_imm, zero_ext, reg_write} = 3'b111;
				end
				mips_pkg::op_ori:
				begin
					alu_op = mips_pkg::alu_or;
					{use_imm, zero_ext, reg_write} = 3'b111;
				end
				mips_pkg::op_lui:
				begin
					alu_op = mips_pkg::alu_lui;
					{use_imm, reg_write} = 2'b11;
				end
				mips_pkg::op_lw:  {use_imm, is_load, reg_write} = 3'b111;
				mips_pkg::op_sw:  {use_imm, is_store} = 2'b11;
				mips_pkg::op_beq: is_beq = 1'b1;
				mips_pkg::op_bne: is_bne = 1'b1;
				mips_pkg::op_j:   is_jump = 1'b1;
				default: ; // Bubble
			endcase
		end
	end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
module reg_file
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic [mips_pkg::reg_addr_w-1:0] rs,
	input  logic [mips_pkg::reg_addr_w-1:0] rt,
	output logic [mips_pkg::data_w-1:0]     rdata_a,
	output logic [mips_pkg::data_w-1:0]     rdata_b,
	input  logic [mips_pkg::reg_addr_w-1:0] wb_rd,
	input  logic [mips_pkg::data_w-1:0]     wb_value,
	input  logic                            wb_we
);

	logic [mips_pkg::data_w-1:0] regs [32];
	logic                        wr_en;

	assign wr_en = wb_we && (wb_rd != '0); // r0 stays zero

	always_ff @(posedge clk)
	begin
		if (rst)
			regs <= '{default: '0};
		else if (wr_en)
			regs[wb_rd] <= wb_value;
	end

	// Write-first bypass
	assign rdata_a = (wr_en && wb_rd == rs) ? wb_value : regs[rs];
	assign rdata_b = (wr_en && wb_rd == rt) ? wb_value : regs[rt];

endmodule

// ==== hw/hazard_unit.sv ====
`timescale 1ns/1ps
module hazard_unit
(
	input  logic [mips_pkg::reg_addr_w-1:0] d_rs,
	input  logic [mips_pkg::reg_addr_w-1:0] d_rt,
	input  logic [mips_pkg::reg_addr_w-1:0] x_rs,
	input  logic [mips_pkg::reg_addr_w-1:0] x_rt,
	input  logic [mips_pkg::reg_addr_w-1:0] x_rd,
	input  logic                            x_is_load,
	input  logic                            x_reg_write,
	input  logic [mips_pkg::reg_addr_w-1:0] m_rd,
	input  logic                            m_reg_write,
	input  logic [mips_pkg::reg_addr_w-1:0] wb_rd,
	input  logic                            wb_we,
	output logic                            stall,
	output mips_pkg::fwd_sel_t              fwd_a,
	output mips_pkg::fwd_sel_t              fwd_b
);

	// Younger memory stage wins over write-back
	function automatic mips_pkg::fwd_sel_t pick_src(
		input logic [mips_pkg::reg_addr_w-1:0] src);
		if (m_reg_write && m_rd != '0 && m_rd == src)
			return mips_pkg::fwd_mem;
		else if (wb_we && wb_rd != '0 && wb_rd == src)
			return mips_pkg::fwd_wb;
		return mips_pkg::fwd_reg;
	endfunction

	always_comb
	begin
		fwd_a = pick_src(x_rs);
		fwd_b = pick_src(x_rt);
	end

	// Load data arrives one stage too late for forwarding
	assign stall = x_is_load && x_reg_write && (x_rd != '0)
		&& (x_rd == d_rs || x_rd == d_rt);

endmodule

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps
module execute_stage
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            stall,
	input  mips_pkg::alu_op_t               d_alu_op,
	input  logic                            d_use_imm,
	input  logic                            d_zero_ext,
	input  logic                            d_is_load,
	input  logic                            d_is_store,
	input  logic                            d_reg_write,
	input  logic                            d_is_beq,
	input  logic                            d_is_bne,
	input  logic                            d_is_jump,
	input  logic [mips_pkg::reg_addr_w-1:0] d_rs,
	input  logic [mips_pkg::reg_addr_w-1:0] d_rt,
	input  logic [mips_pkg::reg_addr_w-1:0] d_rd,
	input  logic [15:0]                     d_imm,
	input  logic [mips_pkg::iaddr_w-1:0]    d_pc,
	input  logic [mips_pkg::data_w-1:0]     rdata_a,
	input  logic [mips_pkg::data_w-1:0]     rdata_b,
	input  mips_pkg::fwd_sel_t              fwd_a,
	input  mips_pkg::fwd_sel_t              fwd_b,
	input  logic [mips_pkg::data_w-1:0]     m_result,
	input  logic [mips_pkg::data_w-1:0]     wb_value,
	output logic [mips_pkg::reg_addr_w-1:0] x_rs,
	output logic [mips_pkg::reg_addr_w-1:0] x_rt,
	output logic [mips_pkg::reg_addr_w-1:0] x_rd,
	output logic                            x_is_load,
	output logic                            x_reg_write,
	output logic                            redirect,
	output logic [mips_pkg::iaddr_w-1:0]    target_pc,
	output logic [mips_pkg::data_w-1:0]     x_result,
	output logic [mips_pkg::data_w-1:0]     x_store_data,
	output logic                            x_is_store
);

	mips_pkg::alu_op_t            x_alu_op;
	logic                         x_use_imm, x_zero_ext;
	logic                         x_is_beq, x_is_bne, x_is_jump;
	logic [15:0]                  x_imm;
	logic [mips_pkg::iaddr_w-1:0] x_pc;
	logic [mips_pkg::data_w-1:0]  x_rdata_a, x_rdata_b;
	logic [mips_pkg::data_w-1:0]  src_a, src_b, imm_ext, alu_b;
	logic                         taken;

	//*******************************************************************
	// Decode/execute register
	//*******************************************************************
	always_ff @(posedge clk)
	begin
		if (rst || stall || redirect)
		begin
			x_is_load   <= 1'b0;
			x_is_store  <= 1'b0;
			x_reg_write <= 1'b0;
			x_is_beq    <= 1'b0;
			x_is_bne    <= 1'b0;
			x_is_jump   <= 1'b0;
		end
		else
		begin
			x_is_load   <= d_is_load;
			x_is_store  <= d_is_store;
			x_reg_write <= d_reg_write;
			x_is_beq    <= d_is_beq;
			x_is_bne    <= d_is_bne;
			x_is_jump   <= d_is_jump;
		end
	end

	always_ff @(posedge clk)
	begin
		x_alu_op   <= d_alu_op;
		x_use_imm  <= d_use_imm;
		x_zero_ext <= d_zero_ext;
		x_rs       <= d_rs;
		x_rt       <= d_rt;
		x_rd       <= d_rd;
		x_imm      <= d_imm;
		x_pc       <= d_pc;
		x_rdata_a  <= rdata_a;
		x_rdata_b  <= rdata_b;
	end

	//*******************************************************************
	// Operands and ALU
	//*******************************************************************
	function automatic logic [mips_pkg::data_w-1:0] fwd_mux(input mips_pkg::fwd_sel_t sel,
		input logic [mips_pkg::data_w-1:0] reg_val);
		case (sel)
			mips_pkg::fwd_mem: return m_result;
			mips_pkg::fwd_wb:  return wb_value;
			default:           return reg_val;
		endcase
	endfunction

	always_comb
	begin
		src_a = fwd_mux(fwd_a, x_rdata_a);
		src_b = fwd_mux(fwd_b, x_rdata_b);
	end

	assign imm_ext = x_zero_ext ? {16'b0, x_imm} : {{16{x_imm[15]}}, x_imm};
	assign alu_b   = x_use_imm ? imm_ext : src_b;

	always_comb
	begin
		case (x_alu_op)
			mips_pkg::alu_add: x_result = src_a + alu_b;
			mips_pkg::alu_sub: x_result = src_a - alu_b;
			mips_pkg::alu_and: x_result = src_a & alu_b;
			mips_pkg::alu_or:  x_result = src_a | alu_b;
			mips_pkg::alu_xor: x_result = src_a ^ alu_b;
			mips_pkg::alu_nor: x_result = ~(src_a | alu_b);
			mips_pkg::alu_lui: x_result = {alu_b[15:0], 16'b0};
			default:           x_result = '0;
		endcase
	end

	assign x_store_data = src_b; // rt after forwarding

	// Branch resolves in execute
	assign taken     = (x_is_beq && src_a == src_b) || (x_is_bne && src_a != src_b);
	assign redirect  = taken || x_is_jump;
	assign target_pc = x_is_jump ? x_imm[mips_pkg::iaddr_w-1:0]
		: x_pc + {{(mips_pkg::iaddr_w-1){1'b0}}, 1'b1} + x_imm[mips_pkg::iaddr_w-1:0];

endmodule

// ==== hw/memory_writeback.sv ====
`timescale 1ns/1ps
module memory_writeback
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic [mips_pkg::data_w-1:0]     x_result,
	input  logic [mips_pkg::data_w-1:0]     x_store_data,
	input  logic [mips_pkg::reg_addr_w-1:0] x_rd,
	input  logic                            x_is_load,
	input  logic                            x_is_store,
	input  logic                            x_reg_write,
	input  logic [mips_pkg::data_w-1:0]     ddout,
	output logic [mips_pkg::daddr_w-1:0]    daddr,
	output logic [mips_pkg::data_w-1:0]     ddin,
	output logic                            dwr,
	output logic [mips_pkg::data_w-1:0]     m_result,
	output logic [mips_pkg::reg_addr_w-1:0] m_rd,
	output logic                            m_reg_write,
	output logic [mips_pkg::data_w-1:0]     wb_value,
	output logic [mips_pkg::reg_addr_w-1:0] wb_rd,
	output logic                            wb_we
);

	logic [mips_pkg::data_w-1:0] m_store_data;
	logic                        m_is_load, m_is_store;
	logic [mips_pkg::data_w-1:0] wb_alu, wb_load;
	logic                        wb_is_load;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			{m_is_load, m_is_store, m_reg_write} <= '0;
			{wb_is_load, wb_we} <= '0;
		end
		else
		begin
			m_is_load   <= x_is_load;
			m_is_store  <= x_is_store;
			m_reg_write <= x_reg_write;
			wb_is_load  <= m_is_load;
			wb_we       <= m_reg_write;
		end
	end

	always_ff @(posedge clk)
	begin
		m_result     <= x_result;
		m_store_data <= x_store_data;
		m_rd         <= x_rd;
		wb_alu       <= m_result;
		wb_load      <= ddout; // Sampled at the end of the memory cycle
		wb_rd        <= m_rd;
	end

	// Data port, single-cycle write strobe
	assign daddr = m_result[mips_pkg::daddr_w-1:0];
	assign ddin  = m_store_data;
	assign dwr   = m_is_store;

	assign wb_value = wb_is_load ? wb_load : wb_alu;

endmodule

// ==== hw/mips_core.sv ====
`timescale 1ns/1ps
module mips_core
(
	input  logic                         clk,
	input  logic                         rst,
	output logic [mips_pkg::iaddr_w-1:0] iaddr,
	input  logic [mips_pkg::data_w-1:0]  idata,
	output logic [mips_pkg::daddr_w-1:0] daddr,
	output logic [mips_pkg::data_w-1:0]  ddin,
	output logic                         dwr,
	input  logic [mips_pkg::data_w-1:0]  ddout
);

	// Fetch to decode
	logic [mips_pkg::data_w-1:0]     d_ir;
	logic [mips_pkg::iaddr_w-1:0]    d_pc;
	logic                            d_valid;

	// Decode outputs
	logic [mips_pkg::reg_addr_w-1:0] d_rs, d_rt, d_rd;
	logic [15:0]                     d_imm;
	mips_pkg::alu_op_t               d_alu_op;
	logic d_use_imm, d_zero_ext, d_is_load, d_is_store, d_reg_write;
	logic d_is_beq, d_is_bne, d_is_jump;
	logic [mips_pkg::data_w-1:0]     rdata_a, rdata_b;

	// Hazards
	logic                            stall;
	mips_pkg::fwd_sel_t              fwd_a, fwd_b;

	// Execute outputs
	logic [mips_pkg::reg_addr_w-1:0] x_rs, x_rt, x_rd;
	logic                            x_is_load, x_is_store, x_reg_write;
	logic                            redirect;
	logic [mips_pkg::iaddr_w-1:0]    target_pc;
	logic [mips_pkg::data_w-1:0]     x_result, x_store_data;

	// Memory and write-back
	logic [mips_pkg::data_w-1:0]     m_result, wb_value;
	logic [mips_pkg::reg_addr_w-1:0] m_rd, wb_rd;
	logic                            m_reg_write, wb_we;

	fetch_stage u_fetch (.clk, .rst, .stall, .redirect, .target_pc, .idata, .iaddr,
		.d_ir, .d_pc, .d_valid);

	decode_unit u_decode (.d_ir, .d_valid, .rs(d_rs), .rt(d_rt), .rd(d_rd), .imm(d_imm),
		.alu_op(d_alu_op), .use_imm(d_use_imm), .zero_ext(d_zero_ext),
		.is_load(d_is_load), .is_store(d_is_store), .reg_write(d_reg_write),
		.is_beq(d_is_beq), .is_bne(d_is_bne), .is_jump(d_is_jump));

	reg_file u_regs (.clk, .rst, .rs(d_rs), .rt(d_rt), .rdata_a, .rdata_b,
		.wb_rd, .wb_value, .wb_we);

	hazard_unit u_hazard (.d_rs, .d_rt, .x_rs, .x_rt, .x_rd, .x_is_load, .x_reg_write,
		.m_rd, .m_reg_write, .wb_rd, .wb_we, .stall, .fwd_a, .fwd_b);

	execute_stage u_execute (.clk, .rst, .stall, .d_alu_op, .d_use_imm, .d_zero_ext,
		.d_is_load, .d_is_store, .d_reg_write, .d_is_beq, .d_is_bne, .d_is_jump,
		.d_rs, .d_rt, .d_rd, .d_imm, .d_pc, .rdata_a, .rdata_b, .fwd_a, .fwd_b,
		.m_result, .wb_value, .x_rs, .x_rt, .x_rd, .x_is_load, .x_reg_write,
		.redirect, .target_pc, .x_result, .x_store_data, .x_is_store);

	memory_writeback u_memwb (.clk, .rst, .x_result, .x_store_data, .x_rd, .x_is_load,
		.x_is_store, .x_reg_write, .ddout, .daddr, .ddin, .dwr, .m_result, .m_rd,
		.m_reg_write, .wb_value, .wb_rd, .wb_we);

endmodule

// ==== tests/mips_core_properties.sv ====
`timescale 1ns/1ps
module mips_core_properties
(
	input logic clk,
	input logic rst,
	input logic dwr,
	input logic stall
);

	//*******************************************************************
	// Pipeline control properties
	//*******************************************************************

	// First cycle out of reset
	dwr_low_after_reset: assert property (@(posedge clk) $fell(rst) |-> !dwr)
		else $error("store strobe high in the first cycle after reset");

	// Load-use costs exactly one cycle
	stall_single_cycle: assert property (@(posedge clk) disable iff (rst)
		stall |=> !stall)
		else $error("stall held for two cycles in a row");

	dwr_low_in_reset: assert property (@(posedge clk) rst ##1 rst |-> !dwr)
		else $error("store strobe high during reset");

endmodule

// ==== tests/tb_mips_core.sv ====
`timescale 1ns/1ps
module tb_mips_core;

	logic                         clk;
	logic                         rst;
	logic [mips_pkg::iaddr_w-1:0] iaddr;
	logic [mips_pkg::data_w-1:0]  idata;
	logic [mips_pkg::daddr_w-1:0] daddr;
	logic [mips_pkg::data_w-1:0]  ddin;
	logic                         dwr;
	logic [mips_pkg::data_w-1:0]  ddout;

	logic [31:0] imem [64] = '{default: '0};
	logic [31:0] dmem [64];
	logic [31:0] init_mem [64]; // Start image copied into dmem during reset
	logic [31:0] model_mem [64];
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	integer      seed;

	mips_core UUT (.clk, .rst, .iaddr, .idata, .daddr, .ddin, .dwr, .ddout);

	bind mips_core mips_core_properties u_props (.clk, .rst, .dwr, .stall);

	assign idata = imem[iaddr];
	assign ddout = rst ? '0 : dmem[daddr];

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk)
	begin
		if (rst)
			dmem <= init_mem;
		else if (dwr)
			dmem[daddr] <= ddin;
	end

	//*******************************************************************
	// Failure reporting and checks
	//*******************************************************************
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Result: FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("error at %0d ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	function automatic logic [31:0] pick(input logic [31:0] n);
		logic [31:0] r;
		r = $random(seed);
		return r % n;
	endfunction

	//*******************************************************************
	// Program generation
	//*******************************************************************
	task automatic make_program();
		logic [5:0]  fns [6];
		logic [5:0]  op;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
		logic [31:0] kind;
		fns = '{mips_pkg::fn_add, mips_pkg::fn_sub, mips_pkg::fn_and, mips_pkg::fn_or,
			mips_pkg::fn_xor, mips_pkg::fn_nor};
		for (int a = 0; a < 64; a++)
		begin
			imem[6'(a)]      = '0;
			init_mem[6'(a)]  = $random(seed);
			model_mem[6'(a)] = init_mem[6'(a)];
		end
		for (int s = 0; s < 40; s++)
		begin
			rs   = 5'(pick(16));
			rt   = 5'(pick(16));
			imm  = 16'($random(seed));
			kind = pick(17);
			case (kind)
				6:       op = mips_pkg::op_andi;
				7:       op = mips_pkg::op_ori;
				8:       op = mips_pkg::op_lui;
				9:       op = mips_pkg::op_lw;
				10:      op = mips_pkg::op_sw;
				11:      op = mips_pkg::op_beq;
				12:      op = mips_pkg::op_bne;
				13:      op = mips_pkg::op_j;
				default: op = mips_pkg::op_addi;
			endcase
			if (kind < 32'd6)
				imem[6'(s)] = {mips_pkg::op_rtype, rs, rt, 5'(pick(16)), 5'b0, fns[3'(kind)]};
			else if (op == mips_pkg::op_j)
				imem[6'(s)] = {op, 20'b0, 6'(s + 1 + pick(40 - s))};
			else if (op == mips_pkg::op_beq || op == mips_pkg::op_bne)
				imem[6'(s)] = {op, rs, rt, 16'(pick(40 - s))}; // Target no later than 40
			else
				imem[6'(s)] = {op, rs, rt, imm};
		end
		// Register dump to 48..62
		for (int k = 1; k < 16; k++)
			imem[6'(39 + k)] = {mips_pkg::op_sw, 5'd0, 5'(k), 16'(47 + k)};
		imem[6'd55] = {mips_pkg::op_j, 20'b0, 6'd55};
	endtask

	//*******************************************************************
	// Instruction-level reference model
	//*******************************************************************
	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] ir;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] val;
		logic [5:0]  pc;
		logic [5:0]  next_pc;
		logic [5:0]  addr;
		logic [4:0]  dst;
		logic        wr;
		regs = '{default: '0};
		pc   = '0;
		while (pc != 6'd55)
		begin
			ir      = imem[pc];
			a       = regs[ir[25:21]];
			b       = regs[ir[20:16]];
			addr    = 6'(a + {{16{ir[15]}}, ir[15:0]});
			next_pc = pc + 6'd1;
			dst     = ir[20:16];
			wr      = 1'b1;
			val     = '0;
			case (ir[31:26])
				mips_pkg::op_rtype:
				begin
					dst = ir[15:11];
					case (ir[5:0])
						mips_pkg::fn_add: val = a + b;
						mips_pkg::fn_sub: val = a - b;
						mips_pkg::fn_and: val = a & b;
						mips_pkg::fn_or:  val = a | b;
						mips_pkg::fn_xor: val = a ^ b;
						mips_pkg::fn_nor: val = ~(a | b);
						default:          wr = 1'b0;
					endcase
				end
				mips_pkg::op_addi: val = a + {{16{ir[15]}}, ir[15:0]};
				mips_pkg::op_andi: val = a & {16'b0, ir[15:0]};
				mips_pkg::op_ori:  val = a | {16'b0, ir[15:0]};
				mips_pkg::op_lui:  val = {ir[15:0], 16'b0};
				mips_pkg::op_lw:   val = model_mem[addr];
				mips_pkg::op_sw:
				begin
					wr = 1'b0;
					model_mem[addr] = b;
					exp_addr.push_back({26'b0, addr});
					exp_data.push_back(b);
				end
				mips_pkg::op_beq:
				begin
					wr = 1'b0;
					if (a == b)
						next_pc = pc + 6'd1 + ir[5:0];
				end
				mips_pkg::op_bne:
				begin
					wr = 1'b0;
					if (a != b)
						next_pc = pc + 6'd1 + ir[5:0];
				end
				mips_pkg::op_j:
				begin
					wr      = 1'b0;
					next_pc = ir[5:0];
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0)
				regs[dst] = val;
			pc = next_pc;
		end
	endtask

	// Store strobes arrive in program order
	always @(negedge clk)
	begin
		if (dwr)
		begin
			if (exp_addr.size() == 0)
				abort_run($sformatf("error at %0d ns: store strobe with no store expected",
					$time));
			else
			begin
				check_value("store address", {26'b0, daddr}, exp_addr.pop_front());
				check_value("store data", ddin, exp_data.pop_front());
			end
		end
	end

	// 250 cycles for each of the eight programs
	initial
	begin
		#(8 * 250 * 40);
		abort_run("timeout: the expected stores did not all appear in time");
	end

	initial
	begin
		seed = 32'h37ca;
		rst  = 1'b1;
		for (int p = 0; p < 8; p++)
		begin
			#1;
			rst = 1'b1;
			make_program();
			run_model();
			repeat (3) @(posedge clk);
			#1;
			rst = 1'b0;
			while (exp_addr.size() != 0)
				@(posedge clk);
			repeat (20) @(posedge clk); // Quiet tail with no strobe allowed
		end
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== all.f ====
hw/mips_pkg.sv
hw/fetch_stage.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/hazard_unit.sv
hw/execute_stage.sv
hw/memory_writeback.sv
hw/mips_core.sv
tests/mips_core_properties.sv
tests/tb_mips_core.sv

// ==== Makefile ====
BIN := obj_dir/Vtb_mips_core

.PHONY: run clean

run: $(BIN)
	./$(BIN)

$(BIN): all.f $(wildcard hw/*.sv tests/*.sv)
	verilator --binary --assert --timescale 1ns/1ps -j 0 --top-module tb_mips_core -f all.f

clean:
	rm -rf obj_dir
